/* design/excp_defs.svh */
`ifndef EXCP_DEFS_SVH
`define EXCP_DEFS_SVH

// CSR numbers of the implemented exception registers
`define CSR_CRMD            14'h000
`define CSR_PRMD            14'h001
`define CSR_ECFG            14'h004
`define CSR_ESTAT           14'h005
`define CSR_ERA             14'h006
`define CSR_BADV            14'h007
`define CSR_EENTRY          14'h00c

`define CSR_ADDR_W          14
`define EXC_CAUSE_W         7
`define EXCEPTION_NOP       7'h3f

`define BUBBLE_PC           32'h000000fc   // Empty slot marker

// Field positions
`define CRMD_IE_BIT         2
`define CRMD_MODE_W         3              // PLV and IE
`define ESTAT_ECODE_LSB     16
`define INT_VEC_W           12             // Bits 12..11 and 9..0
`define EENTRY_LOW_W        6

`endif

/* design/excp_pkg.sv */
`include "excp_defs.svh"

package excp_pkg;

    // Memory stage commit record
    typedef struct packed {
        logic [31:0]                               pc;
        logic [5:0]                                is_exception;    // Higher index wins
        logic [5:0][`EXC_CAUSE_W-1:0]              exception_cause;
        logic [31:0]                               exception_addr;
        logic                                      is_ertn;
        logic                                      is_idle;
    } mem_ctrl_t;

    // Stall requests from the pipeline stages
    typedef struct packed {
        logic pause_if;
        logic pause_id;
        logic pause_dispatch;
        logic pause_ex;
        logic pause_mem;
    } pause_t;

    // CSR write leaving write-back
    typedef struct packed {
        logic                   csr_write_en;
        logic [`CSR_ADDR_W-1:0] csr_write_addr;
        logic [31:0]            csr_write_data;
    } csr_push_forward_t;

    // pause[0] PC, [1] icache, [2] instbuffer, [3] id,
    // [4] dispatch, [5] ex, [6] mem
    typedef struct packed {
        logic [6:0] pause;
        logic       exception_flush;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] exception_new_pc;
        logic        is_interrupt;
    } ctrl_pc_t;

endpackage

/* design/ctrl_csr_if.sv */
`timescale 1ns/1ps
`include "excp_defs.svh"

interface ctrl_csr;

    // CSR state towards the controller
    logic [31:0]               ERA_PC;
    logic [31:0]               EENTRY_VA;
    logic [`INT_VEC_W-1:0]     ECFG_LIE;
    logic [`INT_VEC_W-1:0]     ESTAT_IS;
    logic                      CRMD_IE;

    // Exception events towards the CSR file
    logic                      is_exception;
    logic [`EXC_CAUSE_W-1:0]   exception_cause;
    logic [31:0]               exception_pc;
    logic [31:0]               exception_addr;
    logic                      is_ertn;

    modport master (
        input  ERA_PC, EENTRY_VA, ECFG_LIE, ESTAT_IS, CRMD_IE,
        output is_exception, exception_cause, exception_pc, exception_addr, is_ertn
    );

    modport slave (
        output ERA_PC, EENTRY_VA, ECFG_LIE, ESTAT_IS, CRMD_IE,
        input  is_exception, exception_cause, exception_pc, exception_addr, is_ertn
    );

endinterface

/* design/mem_commit_latch.sv */
`timescale 1ns/1ps
`include "excp_defs.svh"

module mem_commit_latch (
    input  logic                clk,
    input  logic                rst_i,
    input  excp_pkg::mem_ctrl_t mem_i,
    input  logic                hold_i,
    input  logic                flush_i,
    output excp_pkg::mem_ctrl_t mem_o
);

    // Empty slot, the commit logic ignores its exception bits
    localparam excp_pkg::mem_ctrl_t BUBBLE = '{
        pc:              `BUBBLE_PC,
        is_exception:    '0,
        exception_cause: '0,
        exception_addr:  '0,
        is_ertn:         1'b0,
        is_idle:         1'b0
    };

    excp_pkg::mem_ctrl_t mem_q;
    logic                load;

    assign load = !hold_i;   // Memory stage stalled keeps the record

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            mem_q <= BUBBLE;   // Flush beats hold
        end
        else if (load) begin
            mem_q <= mem_i;
        end
    end

    assign mem_o = mem_q;

endmodule

/* design/ctrl.sv */
`timescale 1ns/1ps
`include "excp_defs.svh"

module ctrl (
    input  excp_pkg::pause_t            pause_request_i,
    input  excp_pkg::mem_ctrl_t         mem_i,
    input  excp_pkg::csr_push_forward_t wb_push_forward_i,
    input  logic                        continue_idle_i,
    ctrl_csr.master                     csr_if,
    output excp_pkg::ctrl_t             ctrl_o,
    output excp_pkg::ctrl_pc_t          ctrl_pc_o,
    output logic                        send_inst1_en_o
);

    logic                    wb_en;
    logic [`CSR_ADDR_W-1:0]  wb_addr;
    logic [31:0]             wb_data;
    logic [`INT_VEC_W-1:0]   wb_vec;

    logic [31:0]             era_cur;
    logic [31:0]             eentry_cur;
    logic [`INT_VEC_W-1:0]   lie_cur;
    logic [`INT_VEC_W-1:0]   is_cur;
    logic                    ie_cur;

    logic [`INT_VEC_W-1:0]   int_vec;
    logic                    int_pending;
    logic                    exc_valid;
    logic [`EXC_CAUSE_W-1:0] sel_cause;
    logic                    pause_idle;
    logic [6:0]              pause_vec;
    logic                    flush;

    assign wb_en   = wb_push_forward_i.csr_write_en;
    assign wb_addr = wb_push_forward_i.csr_write_addr;
    assign wb_data = wb_push_forward_i.csr_write_data;
    assign wb_vec  = {wb_data[12:11], wb_data[9:0]};   // Bit 10 not implemented

    // Write-back forwarding of the CSRs the decisions depend on
    assign era_cur    = (wb_en && wb_addr == `CSR_ERA)    ? wb_data : csr_if.ERA_PC;
    assign eentry_cur = (wb_en && wb_addr == `CSR_EENTRY) ? wb_data : csr_if.EENTRY_VA;
    assign lie_cur    = (wb_en && wb_addr == `CSR_ECFG)   ? wb_vec  : csr_if.ECFG_LIE;
    assign is_cur     = (wb_en && wb_addr == `CSR_ESTAT)  ? wb_vec  : csr_if.ESTAT_IS;
    assign ie_cur     = (wb_en && wb_addr == `CSR_CRMD)   ? wb_data[`CRMD_IE_BIT]
                                                          : csr_if.CRMD_IE;

    assign int_vec     = ie_cur ? (lie_cur & is_cur) : '0;
    assign int_pending = (int_vec != '0);

    // Highest set stage bit selects the cause
    always_comb begin
        exc_valid = (mem_i.pc != `BUBBLE_PC) && (mem_i.is_exception != '0);
        sel_cause = `EXCEPTION_NOP;
        for (int i = 0; i < 6; i++) begin
            if (mem_i.is_exception[i]) begin
                sel_cause = mem_i.exception_cause[i];
            end
        end
        if (!exc_valid) begin
            sel_cause = `EXCEPTION_NOP;
        end
    end

    assign csr_if.is_exception    = exc_valid;
    assign csr_if.exception_cause = sel_cause;
    assign csr_if.exception_pc    = mem_i.pc;
    assign csr_if.exception_addr  = mem_i.exception_addr;
    assign csr_if.is_ertn         = mem_i.is_ertn;

    // Bubble still flushes
    assign flush = (mem_i.is_exception != '0) || mem_i.is_ertn;

    // Idle waits for an interrupt or an explicit release
    assign pause_idle = mem_i.is_idle && !int_pending && !continue_idle_i;

    always_comb begin
        if (pause_request_i.pause_if) begin
            pause_vec = 7'b0000001;
        end
        else if (pause_request_i.pause_id) begin
            pause_vec = 7'b0001111;
        end
        else if (pause_request_i.pause_dispatch) begin
            pause_vec = 7'b0011111;
        end
        else if (pause_request_i.pause_ex) begin
            pause_vec = 7'b0111111;
        end
        else if (pause_request_i.pause_mem || pause_idle) begin
            pause_vec = 7'b1111111;
        end
        else begin
            pause_vec = 7'b0000000;
        end
    end

    assign ctrl_o.pause              = pause_vec;
    assign ctrl_o.exception_flush    = flush;
    assign ctrl_pc_o.exception_new_pc = mem_i.is_ertn ? era_cur : eentry_cur;
    assign ctrl_pc_o.is_interrupt    = int_pending;
    assign send_inst1_en_o           = !pause_vec[2];   // Instbuffer stalled

endmodule

/* design/csr_file.sv */
`timescale 1ns/1ps
`include "excp_defs.svh"

module csr_file (
    input  logic                        clk,
    input  logic                        rst_i,
    input  excp_pkg::csr_push_forward_t wb_i,
    input  logic [`CSR_ADDR_W-1:0]      read_addr_i,
    ctrl_csr.slave                      csr_if,
    output logic [31:0]                 read_data_o
);

    logic [`CRMD_MODE_W-1:0]          crmd;       // IE, PLV
    logic [`CRMD_MODE_W-1:0]          prmd;       // PIE, PPLV
    logic [`INT_VEC_W-1:0]            ecfg_lie;
    logic [`INT_VEC_W-1:0]            estat_is;
    logic [`EXC_CAUSE_W-1:0]          estat_ecode;
    logic [31:0]                      era;
    logic [31:0]                      badv;
    logic [31:`EENTRY_LOW_W]          eentry;

    logic                             sw_we;
    logic [31:0]                      sw_data;
    logic [`INT_VEC_W-1:0]            sw_vec;

    logic [31:0]                      ecfg_full;
    logic [31:0]                      estat_full;

    assign sw_we   = wb_i.csr_write_en;
    assign sw_data = wb_i.csr_write_data;
    assign sw_vec  = {sw_data[12:11], sw_data[9:0]};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            crmd        <= '0;   // PLV 0, interrupts off
            prmd        <= '0;
            ecfg_lie    <= '0;
            estat_is    <= '0;
            estat_ecode <= '0;
            era         <= '0;
            badv        <= '0;
            eentry      <= '0;
        end
        else if (csr_if.is_exception) begin
            prmd        <= crmd;
            crmd        <= '0;
            era         <= csr_if.exception_pc;
            badv        <= csr_if.exception_addr;
            estat_ecode <= csr_if.exception_cause;
        end
        else if (csr_if.is_ertn) begin
            crmd <= prmd;
        end
        else if (sw_we) begin
            case (wb_i.csr_write_addr)
                `CSR_CRMD: begin
                    crmd <= sw_data[`CRMD_MODE_W-1:0];
                end
                `CSR_PRMD: begin
                    prmd <= sw_data[`CRMD_MODE_W-1:0];
                end
                `CSR_ECFG: begin
                    ecfg_lie <= sw_vec;
                end
                `CSR_ESTAT: begin
                    estat_is    <= sw_vec;
                    estat_ecode <= '0;   // Only the IS bits survive a write
                end
                `CSR_ERA: begin
                    era <= sw_data;
                end
                `CSR_BADV: begin
                    badv <= sw_data;
                end
                `CSR_EENTRY: begin
                    eentry <= sw_data[31:`EENTRY_LOW_W];
                end
                default: begin
                end
            endcase
        end
    end

    // Bit 10 of the interrupt fields reads as zero
    assign ecfg_full  = {19'b0, ecfg_lie[11:10], 1'b0, ecfg_lie[9:0]};
    assign estat_full = {9'b0, estat_ecode, 3'b0, estat_is[11:10], 1'b0, estat_is[9:0]};

    always_comb begin
        case (read_addr_i)
            `CSR_CRMD:   read_data_o = {{(32-`CRMD_MODE_W){1'b0}}, crmd};
            `CSR_PRMD:   read_data_o = {{(32-`CRMD_MODE_W){1'b0}}, prmd};
            `CSR_ECFG:   read_data_o = ecfg_full;
            `CSR_ESTAT:  read_data_o = estat_full;
            `CSR_ERA:    read_data_o = era;
            `CSR_BADV:   read_data_o = badv;
            `CSR_EENTRY: read_data_o = {eentry, {`EENTRY_LOW_W{1'b0}}};
            default:     read_data_o = 32'b0;
        endcase
    end

    assign csr_if.ERA_PC    = era;
    assign csr_if.EENTRY_VA = {eentry, {`EENTRY_LOW_W{1'b0}}};
    assign csr_if.ECFG_LIE  = ecfg_lie;
    assign csr_if.ESTAT_IS  = estat_is;
    assign csr_if.CRMD_IE   = crmd[`CRMD_IE_BIT];

endmodule

/* design/excp_ctrl_top.sv */
`timescale 1ns/1ps
`include "excp_defs.svh"

module excp_ctrl_top (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic [31:0]              mem_pc_i,
    input  logic [5:0]               mem_is_exception_i,
    input  logic [6*`EXC_CAUSE_W-1:0] mem_exception_cause_i,   // Entry 0 in low bits
    input  logic [31:0]              mem_exception_addr_i,
    input  logic                     mem_is_ertn_i,
    input  logic                     mem_is_idle_i,
    input  logic                     pause_if_i,
    input  logic                     pause_id_i,
    input  logic                     pause_dispatch_i,
    input  logic                     pause_ex_i,
    input  logic                     pause_mem_i,
    input  logic                     continue_idle_i,
    input  logic                     wb_csr_write_en_i,
    input  logic [`CSR_ADDR_W-1:0]   wb_csr_write_addr_i,
    input  logic [31:0]              wb_csr_write_data_i,
    input  logic [`CSR_ADDR_W-1:0]   csr_read_addr_i,
    output logic [6:0]               pause_o,
    output logic                     exception_flush_o,
    output logic [31:0]              exception_new_pc_o,
    output logic                     is_interrupt_o,
    output logic                     send_inst1_en_o,
    output logic [31:0]              csr_read_data_o
);

    excp_pkg::mem_ctrl_t         mem_in;
    excp_pkg::mem_ctrl_t         mem_q;
    excp_pkg::pause_t            pause_req;
    excp_pkg::csr_push_forward_t wb_fwd;
    excp_pkg::ctrl_t             ctrl_out;
    excp_pkg::ctrl_pc_t          ctrl_pc;

    ctrl_csr csr_bus ();

    assign mem_in.pc              = mem_pc_i;
    assign mem_in.is_exception    = mem_is_exception_i;
    assign mem_in.exception_cause = mem_exception_cause_i;
    assign mem_in.exception_addr  = mem_exception_addr_i;
    assign mem_in.is_ertn         = mem_is_ertn_i;
    assign mem_in.is_idle         = mem_is_idle_i;

    assign pause_req = '{pause_if:       pause_if_i,
                         pause_id:       pause_id_i,
                         pause_dispatch: pause_dispatch_i,
                         pause_ex:       pause_ex_i,
                         pause_mem:      pause_mem_i};

    assign wb_fwd = '{csr_write_en:   wb_csr_write_en_i,
                      csr_write_addr: wb_csr_write_addr_i,
                      csr_write_data: wb_csr_write_data_i};

    mem_commit_latch u_latch (
        .clk     (clk),
        .rst_i   (rst_i),
        .mem_i   (mem_in),
        .hold_i  (ctrl_out.pause[6]),       // Memory stage stall
        .flush_i (ctrl_out.exception_flush),
        .mem_o   (mem_q)
    );

    ctrl u_ctrl (
        .pause_request_i   (pause_req),
        .mem_i             (mem_q),
        .wb_push_forward_i (wb_fwd),
        .continue_idle_i   (continue_idle_i),
        .csr_if            (csr_bus.master),
        .ctrl_o            (ctrl_out),
        .ctrl_pc_o         (ctrl_pc),
        .send_inst1_en_o   (send_inst1_en_o)
    );

    csr_file u_csr (
        .clk         (clk),
        .rst_i       (rst_i),
        .wb_i        (wb_fwd),
        .read_addr_i (csr_read_addr_i),
        .csr_if      (csr_bus.slave),
        .read_data_o (csr_read_data_o)
    );

    assign pause_o            = ctrl_out.pause;
    assign exception_flush_o  = ctrl_out.exception_flush;
    assign exception_new_pc_o = ctrl_pc.exception_new_pc;
    assign is_interrupt_o     = ctrl_pc.is_interrupt;

endmodule

/* tests/excp_checker.sv */
`timescale 1ns/1ps
`include "excp_defs.svh"

module excp_checker (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic [2:0]                test_id_i,
    input  logic                      test_end_i,
    input  logic [31:0]               mem_pc_i,
    input  logic [5:0]                mem_is_exception_i,
    input  logic [6*`EXC_CAUSE_W-1:0] mem_exception_cause_i,
    input  logic [31:0]               mem_exception_addr_i,
    input  logic                      mem_is_ertn_i,
    input  logic                      mem_is_idle_i,
    input  logic [4:0]                pause_req_i,   // if, id, dispatch, ex, mem
    input  logic                      continue_idle_i,
    input  logic                      wb_csr_write_en_i,
    input  logic [`CSR_ADDR_W-1:0]    wb_csr_write_addr_i,
    input  logic [31:0]               wb_csr_write_data_i,
    input  logic [`CSR_ADDR_W-1:0]    csr_read_addr_i,
    input  logic [6:0]                pause_i,
    input  logic                      flush_i,
    input  logic [31:0]               new_pc_i,
    input  logic                      is_interrupt_i,
    input  logic                      send_inst1_en_i,
    input  logic [31:0]               csr_read_data_i,
    output int                        tests_run_o,
    output int                        tests_failed_o,
    output int                        errors_o
);

    localparam logic [31:0] VEC_MASK = 32'h0000_1bff;   // Bits 12..11 and 9..0

    // Model of the commit latch and the CSRs
    logic [31:0] lat_pc, lat_addr;
    logic [5:0]  lat_exc;
    logic [41:0] lat_cause;
    logic        lat_ertn, lat_idle;
    logic [31:0] crmd, prmd, ecfg, estat, era, badv, eentry;
    int          test_errors = 0;
    int          test_cycles = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          errors = 0;

    assign tests_run_o    = tests_run;
    assign tests_failed_o = tests_failed;
    assign errors_o       = errors;

    function automatic string test_name(logic [2:0] id);
        case (id)
            3'd1:    return "pause_priority";
            3'd2:    return "exception_entry";
            3'd3:    return "ertn_return";
            3'd4:    return "forwarding";
            3'd5:    return "interrupt_idle";
            default: return "reset_release";
        endcase
    endfunction

    function automatic logic [6:0] pause_vector(logic [4:0] req, logic idle_stall);
        if (req[4]) return 7'b0000001;
        if (req[3]) return 7'b0001111;
        if (req[2]) return 7'b0011111;
        if (req[1]) return 7'b0111111;
        if (req[0] || idle_stall) return 7'b1111111;
        return 7'b0000000;
    endfunction

    function automatic logic [6:0] select_cause(logic [5:0] exc, logic [41:0] causes);
        for (int i = 5; i >= 0; i--) begin
            if (exc[i]) begin
                return causes[i*7 +: 7];   // Highest stage wins
            end
        end
        return `EXCEPTION_NOP;
    endfunction

    function automatic logic interrupt_pending(logic ie, logic [31:0] lie, logic [31:0] is);
        return ie && ((lie & is & VEC_MASK) != '0);
    endfunction

    function automatic logic write_hits(logic [`CSR_ADDR_W-1:0] addr);
        return wb_csr_write_en_i && (wb_csr_write_addr_i == addr);
    endfunction

    function automatic logic [31:0] read_csr(logic [`CSR_ADDR_W-1:0] addr);
        case (addr)
            `CSR_CRMD:   return crmd;
            `CSR_PRMD:   return prmd;
            `CSR_ECFG:   return ecfg;
            `CSR_ESTAT:  return estat;
            `CSR_ERA:    return era;
            `CSR_BADV:   return badv;
            `CSR_EENTRY: return eentry;
            default:     return 32'b0;
        endcase
    endfunction

    task automatic compare_value(input string sig, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if ($isunknown(actual)) begin
            $display("%s: output %s is unknown", test_name(test_id_i), sig);
            test_errors++;
            errors++;
        end
        else if (actual !== expected) begin
            $display("ERR %s %s expected %h actual %h", test_name(test_id_i), sig,
                     expected, actual);
            test_errors++;
            errors++;
        end
    endtask

    task automatic load_bubble();
        lat_pc    = `BUBBLE_PC;
        lat_exc   = '0;
        lat_cause = '0;
        lat_addr  = '0;
        lat_ertn  = 1'b0;
        lat_idle  = 1'b0;
    endtask

    always @(posedge clk) begin
        logic [31:0] era_f, eentry_f, lie_f, is_f;
        logic        ie_f, int_exp, flush_exp, exc_valid;
        logic [6:0]  pause_exp, cause_exp;
        if (rst_i) begin
            load_bubble();
            {crmd, prmd, ecfg, estat, era, badv, eentry} = '0;
        end
        else begin
            // Write-back forwarding into the decisions of this cycle
            era_f    = write_hits(`CSR_ERA) ? wb_csr_write_data_i : era;
            eentry_f = write_hits(`CSR_EENTRY) ? wb_csr_write_data_i : eentry;
            lie_f    = write_hits(`CSR_ECFG) ? wb_csr_write_data_i : ecfg;
            is_f     = write_hits(`CSR_ESTAT) ? wb_csr_write_data_i : estat;
            ie_f     = write_hits(`CSR_CRMD) ? wb_csr_write_data_i[2] : crmd[2];

            int_exp   = interrupt_pending(ie_f, lie_f, is_f);
            pause_exp = pause_vector(pause_req_i, lat_idle && !int_exp && !continue_idle_i);
            flush_exp = (lat_exc != '0) || lat_ertn;
            exc_valid = (lat_pc != `BUBBLE_PC) && (lat_exc != '0);
            cause_exp = select_cause(lat_exc, lat_cause);

            compare_value("pause_o", {25'b0, pause_exp}, {25'b0, pause_i});
            compare_value("send_inst1_en_o", {31'b0, ~pause_exp[2]}, {31'b0, send_inst1_en_i});
            compare_value("exception_flush_o", {31'b0, flush_exp}, {31'b0, flush_i});
            compare_value("exception_new_pc_o", lat_ertn ? era_f : eentry_f, new_pc_i);
            compare_value("is_interrupt_o", {31'b0, int_exp}, {31'b0, is_interrupt_i});
            compare_value("csr_read_data_o", read_csr(csr_read_addr_i), csr_read_data_i);
            test_cycles++;

            if (test_end_i) begin
                tests_run++;
                if (test_errors != 0) begin
                    tests_failed++;
                end
                $display("test %s %s, %0d cycles checked, %0d mismatches", test_name(test_id_i),
                         (test_errors == 0) ? "ok" : "failed", test_cycles, test_errors);
                test_errors = 0;
                test_cycles = 0;
            end

            if (exc_valid) begin
                prmd  = crmd;
                crmd  = '0;
                era   = lat_pc;
                badv  = lat_addr;
                estat = {9'b0, cause_exp, estat[15:0]};
            end
            else if (lat_ertn) begin
                crmd = prmd;
            end
            else if (wb_csr_write_en_i) begin
                case (wb_csr_write_addr_i)
                    `CSR_CRMD:   crmd   = wb_csr_write_data_i & 32'h7;
                    `CSR_PRMD:   prmd   = wb_csr_write_data_i & 32'h7;
                    `CSR_ECFG:   ecfg   = wb_csr_write_data_i & VEC_MASK;
                    `CSR_ESTAT:  estat  = wb_csr_write_data_i & VEC_MASK;   // Cause cleared
                    `CSR_ERA:    era    = wb_csr_write_data_i;
                    `CSR_BADV:   badv   = wb_csr_write_data_i;
                    `CSR_EENTRY: eentry = wb_csr_write_data_i & 32'hffff_ffc0;
                    default:     ;
                endcase
            end

            if (flush_exp) begin
                load_bubble();
            end
            else if (!pause_exp[6]) begin
                lat_pc    = mem_pc_i;
                lat_exc   = mem_is_exception_i;
                lat_cause = mem_exception_cause_i;
                lat_addr  = mem_exception_addr_i;
                lat_ertn  = mem_is_ertn_i;
                lat_idle  = mem_is_idle_i;
            end
        end
    end

endmodule

/* tests/tb_excp_ctrl.sv */
`timescale 1ns/1ps
`include "excp_defs.svh"

module tb_excp_ctrl;

    localparam int N_TESTS = 5;
    localparam int N_PAUSE = 40;
    localparam int N_EXC   = 12;
    localparam int N_ERTN  = 8;
    localparam int N_FWD   = 10;
    localparam int N_INT   = 24;
    // Reset, the tests with one closing cycle each, and the final cycles
    localparam int TEST_CYCLES = 4 + (N_PAUSE + 1) + (4 * N_EXC + 2) + (6 * N_ERTN + 1)
                                 + (3 * N_FWD + 1) + (N_INT + 2 * 11 + 1) + 2;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 50;

    logic        clk, rst_i;
    logic [31:0] mem_pc_i, mem_exception_addr_i;
    logic [5:0]  mem_is_exception_i;
    logic [41:0] mem_exception_cause_i;
    logic        mem_is_ertn_i, mem_is_idle_i, continue_idle_i;
    logic        pause_if_i, pause_id_i, pause_dispatch_i, pause_ex_i, pause_mem_i;
    logic        wb_csr_write_en_i;
    logic [13:0] wb_csr_write_addr_i, csr_read_addr_i;
    logic [31:0] wb_csr_write_data_i;
    logic [6:0]  pause_o;
    logic        exception_flush_o, is_interrupt_o, send_inst1_en_o;
    logic [31:0] exception_new_pc_o, csr_read_data_o;

    logic [2:0]  test_id;
    logic [2:0]  next_id;
    logic        test_end;
    logic [31:0] lfsr_state;
    int          tests_run, tests_failed, errors;
    int          cycle_count = 0;

    excp_ctrl_top uut (.*);

    excp_checker u_checker (
        .*,
        .test_id_i       (test_id),
        .test_end_i      (test_end),
        .pause_req_i     ({pause_if_i, pause_id_i, pause_dispatch_i, pause_ex_i, pause_mem_i}),
        .pause_i         (pause_o),
        .flush_i         (exception_flush_o),
        .new_pc_i        (exception_new_pc_o),
        .is_interrupt_i  (is_interrupt_o),
        .send_inst1_en_i (send_inst1_en_o),
        .csr_read_data_i (csr_read_data_o),
        .tests_run_o     (tests_run),
        .tests_failed_o  (tests_failed),
        .errors_o        (errors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic [13:0] pick_read_addr(logic [2:0] sel);
        case (sel)
            3'd0:    return `CSR_CRMD;
            3'd1:    return `CSR_PRMD;
            3'd2:    return `CSR_ECFG;
            3'd3:    return `CSR_ESTAT;
            3'd4:    return `CSR_ERA;
            3'd5:    return `CSR_BADV;
            3'd6:    return `CSR_EENTRY;
            default: return 14'h010;   // Not implemented, reads zero
        endcase
    endfunction

    task automatic drive_defaults();
        logic [31:0] r;
        take_bits(32, r);
        mem_pc_i              = r;
        mem_is_exception_i    = '0;
        mem_exception_cause_i = '0;
        mem_exception_addr_i  = '0;
        {mem_is_ertn_i, mem_is_idle_i, continue_idle_i, test_end} = '0;
        {pause_if_i, pause_id_i, pause_dispatch_i, pause_ex_i, pause_mem_i} = '0;
        {wb_csr_write_en_i, wb_csr_write_addr_i, wb_csr_write_data_i} = '0;
        take_bits(3, r);
        csr_read_addr_i = pick_read_addr(r[2:0]);
    endtask

    task automatic next_cycle();
        @(negedge clk);
        drive_defaults();
        test_id = next_id;   // A new test takes over after the closing cycle
    endtask

    task automatic csr_write(input logic [13:0] addr, input logic [31:0] data);
        wb_csr_write_en_i   = 1'b1;
        wb_csr_write_addr_i = addr;
        wb_csr_write_data_i = data;
    endtask

    task automatic put_exception();
        logic [31:0] r;
        take_bits(6, r);
        mem_is_exception_i = (r[5:0] == '0) ? 6'b000001 : r[5:0];
        for (int i = 0; i < 6; i++) begin
            take_bits(7, r);
            mem_exception_cause_i[i*7 +: 7] = r[6:0];
        end
        take_bits(32, r);
        mem_exception_addr_i = r;
    endtask

    task automatic end_test();
        next_cycle();
        test_end = 1'b1;
    endtask

    task automatic run_tests();
        logic [31:0] r;
        test_id = 3'd1;
        next_id = 3'd1;
        repeat (N_PAUSE) begin
            next_cycle();
            take_bits(5, r);
            {pause_if_i, pause_id_i, pause_dispatch_i, pause_ex_i, pause_mem_i} = r[4:0];
        end
        end_test();

        next_id = 3'd2;
        next_cycle();
        take_bits(32, r);
        csr_write(`CSR_EENTRY, r);
        for (int i = 0; i < N_EXC; i++) begin
            next_cycle();
            take_bits(3, r);
            csr_write(`CSR_CRMD, r);   // Random PLV and IE
            next_cycle();
            put_exception();
            if (i % 4 == 3) begin
                mem_pc_i = `BUBBLE_PC;
            end
            repeat (2) next_cycle();
        end
        end_test();

        next_id = 3'd3;
        repeat (N_ERTN) begin
            next_cycle();
            take_bits(32, r);
            csr_write(`CSR_ERA, r);
            next_cycle();
            take_bits(3, r);
            csr_write(`CSR_PRMD, r);
            next_cycle();
            take_bits(3, r);
            csr_write(`CSR_CRMD, r);
            next_cycle();
            mem_is_ertn_i = 1'b1;
            repeat (2) next_cycle();
        end
        end_test();

        next_id = 3'd4;
        for (int i = 0; i < N_FWD; i++) begin
            next_cycle();
            if (i % 2 == 1) begin
                mem_is_ertn_i = 1'b1;
            end
            else begin
                put_exception();
            end
            next_cycle();
            take_bits(32, r);
            csr_write((i % 2 == 1) ? `CSR_ERA : `CSR_EENTRY, r);   // Lands with the flush
            next_cycle();
        end
        end_test();

        next_id = 3'd5;
        repeat (N_INT) begin
            next_cycle();
            take_bits(2, r);
            csr_write((r[1:0] == 2'd0) ? `CSR_CRMD : (r[1:0] == 2'd2) ? `CSR_ESTAT : `CSR_ECFG,
                      32'h0);
            take_bits(32, r);
            wb_csr_write_data_i = r;
        end
        for (int k = 0; k < 2; k++) begin
            next_cycle();
            csr_write(`CSR_CRMD, 32'h4);
            next_cycle();
            csr_write(`CSR_ESTAT, 32'h1);
            next_cycle();
            csr_write(`CSR_ECFG, 32'h0);
            next_cycle();
            mem_is_idle_i = 1'b1;
            repeat (4) next_cycle();   // Idle holds the pipeline
            next_cycle();
            if (k == 0) begin
                csr_write(`CSR_ECFG, 32'h1);
            end
            else begin
                continue_idle_i = 1'b1;
            end
            repeat (2) next_cycle();
        end
        end_test();
    endtask

    initial begin
        lfsr_state = 32'hc4a9_fa83;
        rst_i      = 1'b1;
        test_id    = 3'd0;
        next_id    = 3'd0;
        drive_defaults();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        run_tests();
        repeat (2) next_cycle();
        $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0 && tests_run == N_TESTS) begin
            $display("Simulation finished: PASS");
        end
        else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+design
design/excp_pkg.sv
design/ctrl_csr_if.sv
design/mem_commit_latch.sv
design/ctrl.sv
design/csr_file.sv
design/excp_ctrl_top.sv
tests/excp_checker.sv
tests/tb_excp_ctrl.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f flist.f --top-module tb_excp_ctrl -Mdir obj_dir -o sim_excp \
    && ./obj_dir/sim_excp | tee /dev/stderr | grep "Simulation finished: PASS" > /dev/null \
    && echo "run_sim: passed" \
    || { echo "run_sim: failed"; exit 1; }
